// File: verilog/unwrap_macros.svh
/*
 * Burst unwrapper build constants
 * Bus widths and the number of outstanding read bursts
 */
`ifndef UNWRAP_MACROS_SVH
`define UNWRAP_MACROS_SVH

// Bus widths
`define UNWRAP_ADDR_W 32
`define UNWRAP_DATA_W 64
`define UNWRAP_ID_W 4

// Upstream bursts that may wait for R data
`define UNWRAP_MAX_TXNS 4

`endif

// File: verilog/unwrap_pkg.sv
/*
 * Burst unwrapper package
 * AXI field types, burst encodings and the bus payload types
 */
`include "unwrap_macros.svh"

package unwrap_pkg;

  // ----------------------------------------
  // AXI field types
  // ----------------------------------------
  typedef logic [1:0] burst_t;
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;
  typedef logic [1:0] resp_t;

  // Beat count of a burst, 1 to 256
  typedef logic [8:0] beats_t;

  // AXI burst kinds
  localparam burst_t BURST_FIXED = 2'd0;
  localparam burst_t BURST_INCR  = 2'd1;
  localparam burst_t BURST_WRAP  = 2'd2;

  // ----------------------------------------
  // Bus payload types
  // ----------------------------------------
  typedef logic [`UNWRAP_ADDR_W-1:0] addr_t;
  typedef logic [`UNWRAP_ID_W-1:0]   id_t;
  typedef logic [`UNWRAP_DATA_W-1:0] data_t;

endpackage

// File: verilog/axi_ar_if.sv
/*
 * AXI read address channel
 * Manager drives the request, subordinate returns ready
 */
`timescale 1ns/100ps

interface axi_ar_if;

  unwrap_pkg::addr_t  addr;
  unwrap_pkg::id_t    id;
  unwrap_pkg::len_t   len;
  unwrap_pkg::size_t  size;
  unwrap_pkg::burst_t burst;
  logic               valid;
  logic               ready;

  modport manager (
    output addr, id, len, size, burst, valid,
    input  ready
  );

  modport subordinate (
    input  addr, id, len, size, burst, valid,
    output ready
  );

endinterface

// File: verilog/axi_r_if.sv
/*
 * AXI read data channel
 * Subordinate drives the beat, manager returns ready
 */
`timescale 1ns/100ps

interface axi_r_if;

  unwrap_pkg::data_t data;
  unwrap_pkg::id_t   id;
  unwrap_pkg::resp_t resp;
  logic              last;
  logic              valid;
  logic              ready;

  modport manager (
    input  data, id, resp, last, valid,
    output ready
  );

  modport subordinate (
    output data, id, resp, last, valid,
    input  ready
  );

endinterface

// File: verilog/ar_wrap_splitter.sv
/*
 * AR wrap splitter
 * Turns each upstream read request into one or two INCR requests.
 * An unaligned WRAP burst leaves as start..container end, then boundary..start
 */
`timescale 1ns/100ps

module ar_wrap_splitter (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  unwrap_pkg::addr_t  ar_addr_i,
  input  unwrap_pkg::id_t    ar_id_i,
  input  unwrap_pkg::len_t   ar_len_i,
  input  unwrap_pkg::size_t  ar_size_i,
  input  unwrap_pkg::burst_t ar_burst_i,
  input  logic               ar_valid_i,
  output logic               ar_ready_o,
  input  logic               fifo_full_i,
  axi_ar_if.manager          dn,
  output logic               push_o,
  output unwrap_pkg::beats_t push_count_o
);

  typedef enum logic {ST_IDLE, ST_BUSY} state_e;

  state_e             state_q, state_d;
  unwrap_pkg::beats_t beats;
  unwrap_pkg::addr_t  container;
  unwrap_pkg::addr_t  boundary;
  unwrap_pkg::addr_t  first_beats;
  unwrap_pkg::addr_t  second_beats;
  logic               need_split;
  logic               load_sec;

  // Second half of a split, held until it transfers
  unwrap_pkg::addr_t  sec_addr_q;
  unwrap_pkg::id_t    sec_id_q;
  unwrap_pkg::len_t   sec_len_q;
  unwrap_pkg::size_t  sec_size_q;

  // ----------------------------------------
  // Wrap geometry
  // ----------------------------------------
  assign beats     = unwrap_pkg::beats_t'(ar_len_i) + 9'd1;
  // Container size is a power of two for legal WRAP bursts
  assign container = unwrap_pkg::addr_t'(beats) << ar_size_i;
  assign boundary  = ar_addr_i & ~(container - 1'b1);

  assign first_beats  = (boundary + container - ar_addr_i) >> ar_size_i;
  assign second_beats = (ar_addr_i - boundary) >> ar_size_i;

  assign need_split = (ar_burst_i == unwrap_pkg::BURST_WRAP) && (ar_addr_i != boundary);

  // Original length always goes into the queue
  assign push_count_o = beats;

  // ----------------------------------------
  // Request FSM
  // ----------------------------------------
  always_comb begin
    state_d    = state_q;
    load_sec   = 1'b0;
    ar_ready_o = 1'b0;
    push_o     = 1'b0;
    dn.valid   = 1'b0;
    dn.addr    = ar_addr_i;
    dn.id      = ar_id_i;
    dn.len     = ar_len_i;
    dn.size    = ar_size_i;
    dn.burst   = ar_burst_i;

    case (state_q)
      ST_IDLE: begin
        // Hold off while the beat count queue has no room
        if (ar_valid_i && !fifo_full_i) begin
          dn.valid = 1'b1;
          if (ar_burst_i == unwrap_pkg::BURST_WRAP) begin
            dn.burst = unwrap_pkg::BURST_INCR;
          end
          if (need_split) begin
            dn.len = unwrap_pkg::len_t'(first_beats - 1'b1);
          end
          if (dn.ready) begin
            ar_ready_o = 1'b1;
            push_o     = 1'b1;
            if (need_split) begin
              load_sec = 1'b1;
              state_d  = ST_BUSY;
            end
          end
        end
      end
      ST_BUSY: begin
        dn.valid = 1'b1;
        dn.addr  = sec_addr_q;
        dn.id    = sec_id_q;
        dn.len   = sec_len_q;
        dn.size  = sec_size_q;
        dn.burst = unwrap_pkg::BURST_INCR;
        if (dn.ready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_sec) begin
      sec_addr_q <= boundary;
      sec_id_q   <= ar_id_i;
      sec_len_q  <= unwrap_pkg::len_t'(second_beats - 1'b1);
      sec_size_q <= ar_size_i;
    end
  end

endmodule

// File: verilog/beat_count_fifo.sv
/*
 * Beat count FIFO
 * Keeps the original beat count of every accepted read burst, in order
 */
`timescale 1ns/100ps
`include "unwrap_macros.svh"

module beat_count_fifo #(
  parameter int unsigned DEPTH = `UNWRAP_MAX_TXNS
) (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               push_i,
  input  unwrap_pkg::beats_t push_count_i,
  input  logic               pop_i,
  output logic               full_o,
  output logic               not_empty_o,
  output unwrap_pkg::beats_t head_count_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push_ok;
  logic               pop_ok;
  unwrap_pkg::beats_t mem_q [DEPTH];

  // Circular pointer step, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    return nxt;
  endfunction

  assign full_o       = (count_q == CNT_W'(DEPTH));
  assign not_empty_o  = (count_q != '0);
  assign head_count_o = mem_q[rd_ptr_q];

  assign push_ok = push_i && !full_o;
  assign pop_ok  = pop_i && not_empty_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // Occupancy stays put on push and pop together
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= push_count_i;
    end
  end

endmodule

// File: verilog/r_last_rebuild.sv
/*
 * R last rebuild
 * Passes downstream R beats upstream and sets last from the queued
 * beat count, so both halves of a split read leave as one burst
 */
`timescale 1ns/100ps

module r_last_rebuild (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  unwrap_pkg::data_t  m_r_data_i,
  input  unwrap_pkg::id_t    m_r_id_i,
  input  unwrap_pkg::resp_t  m_r_resp_i,
  input  logic               m_r_valid_i,
  output logic               m_r_ready_o,
  input  logic               not_empty_i,
  input  unwrap_pkg::beats_t head_count_i,
  axi_r_if.subordinate       up,
  output logic               pop_o
);

  unwrap_pkg::beats_t beat_index_q;
  logic               is_last;
  logic               xfer;

  // ----------------------------------------
  // Beat pass-through
  // ----------------------------------------
  // Beats only move once their burst length is known
  assign up.valid    = m_r_valid_i && not_empty_i;
  assign m_r_ready_o = up.ready && not_empty_i;

  assign up.data = m_r_data_i;
  assign up.id   = m_r_id_i;
  assign up.resp = m_r_resp_i;

  // ----------------------------------------
  // Last flag
  // ----------------------------------------
  assign is_last = (beat_index_q == head_count_i - 9'd1);
  assign up.last = up.valid && is_last;

  assign xfer  = up.valid && up.ready;
  // Burst is done, release its count
  assign pop_o = xfer && is_last;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      beat_index_q <= '0;
    end else if (xfer) begin
      if (is_last) begin
        beat_index_q <= '0;
      end else begin
        beat_index_q <= beat_index_q + 9'd1;
      end
    end
  end

endmodule

// File: verilog/burst_unwrap_top.sv
/*
 * AXI4 read burst unwrapper
 * Splits unaligned WRAP reads into INCR bursts downstream and
 * returns one upstream R burst of the original length
 */
`timescale 1ns/100ps

module burst_unwrap_top (
  input  logic               clk_i,
  input  logic               arst_n_i,
  // Upstream AR
  input  unwrap_pkg::addr_t  s_ar_addr_i,
  input  unwrap_pkg::id_t    s_ar_id_i,
  input  unwrap_pkg::len_t   s_ar_len_i,
  input  unwrap_pkg::size_t  s_ar_size_i,
  input  unwrap_pkg::burst_t s_ar_burst_i,
  input  logic               s_ar_valid_i,
  output logic               s_ar_ready_o,
  // Downstream AR
  output unwrap_pkg::addr_t  m_ar_addr_o,
  output unwrap_pkg::id_t    m_ar_id_o,
  output unwrap_pkg::len_t   m_ar_len_o,
  output unwrap_pkg::size_t  m_ar_size_o,
  output unwrap_pkg::burst_t m_ar_burst_o,
  output logic               m_ar_valid_o,
  input  logic               m_ar_ready_i,
  // Downstream R, its last is not used
  input  unwrap_pkg::data_t  m_r_data_i,
  input  unwrap_pkg::id_t    m_r_id_i,
  input  unwrap_pkg::resp_t  m_r_resp_i,
  input  logic               m_r_valid_i,
  output logic               m_r_ready_o,
  // Upstream R
  output unwrap_pkg::data_t  s_r_data_o,
  output unwrap_pkg::id_t    s_r_id_o,
  output unwrap_pkg::resp_t  s_r_resp_o,
  output logic               s_r_last_o,
  output logic               s_r_valid_o,
  input  logic               s_r_ready_i
);

  logic               push;
  logic               pop;
  logic               fifo_full;
  logic               fifo_not_empty;
  unwrap_pkg::beats_t push_count;
  unwrap_pkg::beats_t head_count;

  axi_ar_if ar_dn ();
  axi_r_if  r_up ();

  // ----------------------------------------
  // Port mapping
  // ----------------------------------------
  assign m_ar_addr_o  = ar_dn.addr;
  assign m_ar_id_o    = ar_dn.id;
  assign m_ar_len_o   = ar_dn.len;
  assign m_ar_size_o  = ar_dn.size;
  assign m_ar_burst_o = ar_dn.burst;
  assign m_ar_valid_o = ar_dn.valid;
  assign ar_dn.ready  = m_ar_ready_i;

  assign s_r_data_o  = r_up.data;
  assign s_r_id_o    = r_up.id;
  assign s_r_resp_o  = r_up.resp;
  assign s_r_last_o  = r_up.last;
  assign s_r_valid_o = r_up.valid;
  assign r_up.ready  = s_r_ready_i;

  // ----------------------------------------
  // Instances
  // ----------------------------------------
  ar_wrap_splitter u_ar_wrap_splitter (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .ar_addr_i    (s_ar_addr_i),
    .ar_id_i      (s_ar_id_i),
    .ar_len_i     (s_ar_len_i),
    .ar_size_i    (s_ar_size_i),
    .ar_burst_i   (s_ar_burst_i),
    .ar_valid_i   (s_ar_valid_i),
    .ar_ready_o   (s_ar_ready_o),
    .fifo_full_i  (fifo_full),
    .dn           (ar_dn.manager),
    .push_o       (push),
    .push_count_o (push_count)
  );

  beat_count_fifo u_beat_count_fifo (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .push_i       (push),
    .push_count_i (push_count),
    .pop_i        (pop),
    .full_o       (fifo_full),
    .not_empty_o  (fifo_not_empty),
    .head_count_o (head_count)
  );

  r_last_rebuild u_r_last_rebuild (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .m_r_data_i   (m_r_data_i),
    .m_r_id_i     (m_r_id_i),
    .m_r_resp_i   (m_r_resp_i),
    .m_r_valid_i  (m_r_valid_i),
    .m_r_ready_o  (m_r_ready_o),
    .not_empty_i  (fifo_not_empty),
    .head_count_i (head_count),
    .up           (r_up.subordinate),
    .pop_o        (pop)
  );

endmodule

// File: testbench/burst_unwrap_checker.sv
/*
 * Protocol checker for the burst unwrapper
 * Watches the downstream AR and upstream R ports of the top level
 */
`timescale 1ns/100ps

module burst_unwrap_checker (
  input logic               clk_i,
  input logic               arst_n_i,
  input logic               ar_up_valid_i,
  input logic               ar_up_ready_i,
  input unwrap_pkg::addr_t  ar_dn_addr_i,
  input unwrap_pkg::id_t    ar_dn_id_i,
  input unwrap_pkg::len_t   ar_dn_len_i,
  input unwrap_pkg::size_t  ar_dn_size_i,
  input unwrap_pkg::burst_t ar_dn_burst_i,
  input logic               ar_dn_valid_i,
  input logic               ar_dn_ready_i,
  input logic               r_up_last_i,
  input logic               r_up_valid_i,
  input logic               r_up_ready_i
);

  // Upstream bursts accepted and not yet closed on R
  logic [3:0] open_q;

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      open_q <= '0;
    end else begin
      open_q <= open_q + 4'(ar_up_valid_i && ar_up_ready_i)
                       - 4'(r_up_valid_i && r_up_ready_i && r_up_last_i);
    end
  end

  // ----------------------------------------
  // Downstream AR holds until transfer
  ar_hold_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    ar_dn_valid_i && !ar_dn_ready_i |=> ar_dn_valid_i && $stable(ar_dn_addr_i)
      && $stable(ar_dn_id_i) && $stable(ar_dn_len_i) && $stable(ar_dn_size_i)
      && $stable(ar_dn_burst_i)
  ) else begin
    $error("Downstream AR dropped or changed before its transfer");
    fail_count++;
  end

  // R beats only for accepted bursts
  r_open_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    r_up_valid_i |-> (open_q != 4'd0)
  ) else begin
    $error("Upstream R valid with no accepted burst outstanding");
    fail_count++;
  end

  r_last_a : assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    r_up_last_i |-> r_up_valid_i
  ) else begin
    $error("Upstream R last raised without valid");
    fail_count++;
  end

endmodule

// File: testbench/tb_burst_unwrap.sv
/*
 * Testbench for the AXI4 read burst unwrapper
 * Applies a table of read bursts, models the downstream memory and
 * checks the downstream requests and the rebuilt upstream R bursts
 */
`timescale 1ns/100ps

module tb_burst_unwrap;

  localparam int NUM_ROWS      = 10;
  localparam int AR_TIMEOUT    = 200;
  localparam int BEAT_TIMEOUT  = 200;
  localparam int DRAIN_TIMEOUT = 4000;

  typedef struct packed {
    unwrap_pkg::addr_t  addr;
    unwrap_pkg::len_t   len;
    unwrap_pkg::size_t  size;
    unwrap_pkg::burst_t burst;
    logic               split;
    unwrap_pkg::addr_t  dn_addr0;
    unwrap_pkg::len_t   dn_len0;
    unwrap_pkg::addr_t  dn_addr1;
    unwrap_pkg::len_t   dn_len1;
  } row_t;

  typedef struct packed {
    unwrap_pkg::addr_t  addr;
    unwrap_pkg::id_t    id;
    unwrap_pkg::len_t   len;
    unwrap_pkg::size_t  size;
    unwrap_pkg::burst_t burst;
  } ar_req_t;

  typedef struct packed {
    unwrap_pkg::data_t data;
    unwrap_pkg::id_t   id;
    unwrap_pkg::resp_t resp;
    logic              last;
  } r_beat_t;

  logic               clk_i;
  logic               arst_n_i;
  unwrap_pkg::addr_t  s_ar_addr_i;
  unwrap_pkg::id_t    s_ar_id_i;
  unwrap_pkg::len_t   s_ar_len_i;
  unwrap_pkg::size_t  s_ar_size_i;
  unwrap_pkg::burst_t s_ar_burst_i;
  logic               s_ar_valid_i;
  logic               s_ar_ready_o;
  unwrap_pkg::addr_t  m_ar_addr_o;
  unwrap_pkg::id_t    m_ar_id_o;
  unwrap_pkg::len_t   m_ar_len_o;
  unwrap_pkg::size_t  m_ar_size_o;
  unwrap_pkg::burst_t m_ar_burst_o;
  logic               m_ar_valid_o;
  logic               m_ar_ready_i;
  unwrap_pkg::data_t  m_r_data_i;
  unwrap_pkg::id_t    m_r_id_i;
  unwrap_pkg::resp_t  m_r_resp_i;
  logic               m_r_valid_i;
  logic               m_r_ready_o;
  unwrap_pkg::data_t  s_r_data_o;
  unwrap_pkg::id_t    s_r_id_o;
  unwrap_pkg::resp_t  s_r_resp_o;
  logic               s_r_last_o;
  logic               s_r_valid_o;
  logic               s_r_ready_i;

  row_t    stim [NUM_ROWS];
  ar_req_t exp_ar_q [$];
  ar_req_t dn_req_q [$];
  r_beat_t exp_r_q [$];
  ar_req_t ar_exp;
  ar_req_t ar_seen;
  r_beat_t r_exp;
  integer  seed = 61764;

  burst_unwrap_top u_burst_unwrap_top (.*);

  bind burst_unwrap_top burst_unwrap_checker u_checker (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .ar_up_valid_i (s_ar_valid_i),
    .ar_up_ready_i (s_ar_ready_o),
    .ar_dn_addr_i  (m_ar_addr_o),
    .ar_dn_id_i    (m_ar_id_o),
    .ar_dn_len_i   (m_ar_len_o),
    .ar_dn_size_i  (m_ar_size_o),
    .ar_dn_burst_i (m_ar_burst_o),
    .ar_dn_valid_i (m_ar_valid_o),
    .ar_dn_ready_i (m_ar_ready_i),
    .r_up_last_i   (s_r_last_o),
    .r_up_valid_i  (s_r_valid_o),
    .r_up_ready_i  (s_r_ready_i)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h",
               $time, name, actual, expected);
      stop_with_failure();
    end
  endtask

  // Address of one beat under the AXI burst rules
  function automatic unwrap_pkg::addr_t beat_addr(input unwrap_pkg::addr_t addr,
      input unwrap_pkg::len_t len, input unwrap_pkg::size_t size,
      input unwrap_pkg::burst_t burst, input int beat);
    unwrap_pkg::addr_t step;
    unwrap_pkg::addr_t span;
    unwrap_pkg::addr_t base;
    step = unwrap_pkg::addr_t'(beat) << size;
    span = (unwrap_pkg::addr_t'(len) + unwrap_pkg::addr_t'(1)) << size;
    base = addr - (addr % span);
    case (burst)
      unwrap_pkg::BURST_FIXED: return addr;
      unwrap_pkg::BURST_WRAP:  return base + ((addr - base + step) % span);
      default:                 return addr + step;
    endcase
  endfunction

  // Columns: addr, len, size, burst, split, first addr/len, second addr/len
  task automatic load_stimulus();
    stim[0] = '{32'h40, 8'd3, 3'd3, unwrap_pkg::BURST_WRAP, 1'b0, 32'h40, 8'd3, 32'h0, 8'd0};
    stim[1] = '{32'h50, 8'd3, 3'd3, unwrap_pkg::BURST_WRAP, 1'b1, 32'h50, 8'd1, 32'h40, 8'd1};
    stim[2] = '{32'h1000, 8'd7, 3'd3, unwrap_pkg::BURST_INCR, 1'b0, 32'h1000, 8'd7, 32'h0, 8'd0};
    stim[3] = '{32'h2008, 8'd2, 3'd3, unwrap_pkg::BURST_FIXED, 1'b0, 32'h2008, 8'd2, 32'h0, 8'd0};
    stim[4] = '{32'h38, 8'd7, 3'd3, unwrap_pkg::BURST_WRAP, 1'b1, 32'h38, 8'd0, 32'h0, 8'd6};
    stim[5] = '{32'h104, 8'd1, 3'd2, unwrap_pkg::BURST_WRAP, 1'b1, 32'h104, 8'd0, 32'h100, 8'd0};
    stim[6] = '{32'h2A0, 8'd15, 3'd2, unwrap_pkg::BURST_WRAP, 1'b1, 32'h2A0, 8'd7, 32'h280, 8'd7};
    stim[7] = '{32'h3000, 8'd0, 3'd3, unwrap_pkg::BURST_INCR, 1'b0, 32'h3000, 8'd0, 32'h0, 8'd0};
    stim[8] = '{32'h3C0, 8'd3, 3'd2, unwrap_pkg::BURST_WRAP, 1'b0, 32'h3C0, 8'd3, 32'h0, 8'd0};
    stim[9] = '{32'h48C, 8'd7, 3'd2, unwrap_pkg::BURST_WRAP, 1'b1, 32'h48C, 8'd4, 32'h480, 8'd2};
  endtask

  // Downstream requests and upstream beats that one row should produce
  task automatic queue_expected(input int r);
    ar_req_t req;
    r_beat_t beat;
    req.addr  = stim[r].dn_addr0;
    req.id    = unwrap_pkg::id_t'(r);
    req.len   = stim[r].dn_len0;
    req.size  = stim[r].size;
    req.burst = (stim[r].burst == unwrap_pkg::BURST_WRAP) ? unwrap_pkg::BURST_INCR
                                                          : stim[r].burst;
    exp_ar_q.push_back(req);
    if (stim[r].split) begin
      req.addr = stim[r].dn_addr1;
      req.len  = stim[r].dn_len1;
      exp_ar_q.push_back(req);
    end
    for (int b = 0; b <= int'(stim[r].len); b++) begin
      beat.data = unwrap_pkg::data_t'(beat_addr(stim[r].addr, stim[r].len, stim[r].size,
                                                stim[r].burst, b));
      beat.id   = unwrap_pkg::id_t'(r);
      beat.resp = unwrap_pkg::resp_t'(r);
      beat.last = (b == int'(stim[r].len));
      exp_r_q.push_back(beat);
    end
  endtask

  // ----------------------------------------
  // Random ready on both sides
  // ----------------------------------------
  initial begin : ready_gen
    m_ar_ready_i = 1'b0;
    s_r_ready_i  = 1'b0;
    forever begin
      @(negedge clk_i);
      m_ar_ready_i = (($random(seed) & 3) != 0);
      s_r_ready_i  = (($random(seed) & 3) != 0);
    end
  end

  // Checker assertion failures end the run
  always @(negedge clk_i) begin
    if (u_burst_unwrap_top.u_checker.fail_count != 0) begin
      $display("Protocol checker assertion failed before %0t ns", $time);
      stop_with_failure();
    end
  end

  // Downstream AR monitor
  always @(posedge clk_i) begin
    if (arst_n_i && m_ar_valid_o && m_ar_ready_i) begin
      if (exp_ar_q.size() == 0) begin
        $display("Downstream AR at %0t ns that no upstream burst asked for", $time);
        stop_with_failure();
      end else begin
        ar_exp = exp_ar_q.pop_front();
        check_value("m_ar_addr_o", 64'(m_ar_addr_o), 64'(ar_exp.addr));
        check_value("m_ar_id_o", 64'(m_ar_id_o), 64'(ar_exp.id));
        check_value("m_ar_len_o", 64'(m_ar_len_o), 64'(ar_exp.len));
        check_value("m_ar_size_o", 64'(m_ar_size_o), 64'(ar_exp.size));
        check_value("m_ar_burst_o", 64'(m_ar_burst_o), 64'(ar_exp.burst));
        ar_seen = '{m_ar_addr_o, m_ar_id_o, m_ar_len_o, m_ar_size_o, m_ar_burst_o};
        dn_req_q.push_back(ar_seen);
      end
    end
  end

  // Downstream memory, answers requests in order with the beat address
  initial begin : r_model
    ar_req_t req;
    logic    sent;
    m_r_valid_i = 1'b0;
    m_r_data_i  = '0;
    m_r_id_i    = '0;
    m_r_resp_i  = '0;
    forever begin
      @(negedge clk_i);
      if (dn_req_q.size() != 0) begin
        req = dn_req_q.pop_front();
        for (int b = 0; b <= int'(req.len); b++) begin
          m_r_valid_i = 1'b1;
          m_r_data_i  = unwrap_pkg::data_t'(beat_addr(req.addr, req.len, req.size,
                                                      req.burst, b));
          m_r_id_i    = req.id;
          // Response code follows the id so that it differs between bursts
          m_r_resp_i  = unwrap_pkg::resp_t'(req.id);
          sent = 1'b0;
          for (int w = 0; w < BEAT_TIMEOUT && !sent; w++) begin
            @(posedge clk_i);
            sent = m_r_ready_o;
          end
          if (!sent) begin
            $display("Timeout: downstream R beat %0d at 0x%0h was never taken", b, req.addr);
            stop_with_failure();
          end
          @(negedge clk_i);
        end
        m_r_valid_i = 1'b0;
      end
    end
  end

  // Upstream R monitor
  always @(posedge clk_i) begin
    if (arst_n_i && s_r_valid_o && s_r_ready_i) begin
      if (exp_r_q.size() == 0) begin
        $display("Upstream R beat at %0t ns with no burst waiting for it", $time);
        stop_with_failure();
      end else begin
        r_exp = exp_r_q.pop_front();
        check_value("s_r_data_o", 64'(s_r_data_o), 64'(r_exp.data));
        check_value("s_r_id_o", 64'(s_r_id_o), 64'(r_exp.id));
        check_value("s_r_last_o", 64'(s_r_last_o), 64'(r_exp.last));
        check_value("s_r_resp_o", 64'(s_r_resp_o), 64'(r_exp.resp));
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin : main_seq
    logic accepted;
    logic drained;
    arst_n_i     = 1'b0;
    s_ar_addr_i  = '0;
    s_ar_id_i    = '0;
    s_ar_len_i   = '0;
    s_ar_size_i  = '0;
    s_ar_burst_i = unwrap_pkg::BURST_INCR;
    s_ar_valid_i = 1'b0;
    load_stimulus();
    repeat (2) @(negedge clk_i);
    arst_n_i = 1'b1;

    @(posedge clk_i);
    check_value("m_ar_valid_o", 64'(m_ar_valid_o), 64'd0);
    check_value("s_ar_ready_o", 64'(s_ar_ready_o), 64'd0);
    check_value("s_r_valid_o", 64'(s_r_valid_o), 64'd0);
    check_value("m_r_ready_o", 64'(m_r_ready_o), 64'd0);

    for (int r = 0; r < NUM_ROWS; r++) begin
      @(negedge clk_i);
      queue_expected(r);
      s_ar_addr_i  = stim[r].addr;
      s_ar_id_i    = unwrap_pkg::id_t'(r);
      s_ar_len_i   = stim[r].len;
      s_ar_size_i  = stim[r].size;
      s_ar_burst_i = stim[r].burst;
      s_ar_valid_i = 1'b1;
      accepted = 1'b0;
      for (int w = 0; w < AR_TIMEOUT && !accepted; w++) begin
        @(posedge clk_i);
        accepted = s_ar_ready_o;
      end
      if (!accepted) begin
        $display("Timeout: upstream AR of row %0d was never accepted", r);
        stop_with_failure();
      end
    end
    @(negedge clk_i);
    s_ar_valid_i = 1'b0;

    // All requests out and every beat back upstream
    drained = 1'b0;
    for (int w = 0; w < DRAIN_TIMEOUT && !drained; w++) begin
      @(negedge clk_i);
      drained = (exp_r_q.size() == 0) && (exp_ar_q.size() == 0);
    end
    if (!drained) begin
      $display("Timeout: %0d upstream beats still missing at the end", exp_r_q.size());
      stop_with_failure();
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/unwrap_pkg.sv
verilog/axi_ar_if.sv
verilog/axi_r_if.sv
verilog/ar_wrap_splitter.sv
verilog/beat_count_fifo.sv
verilog/r_last_rebuild.sv
verilog/burst_unwrap_top.sv
testbench/burst_unwrap_checker.sv
testbench/tb_burst_unwrap.sv

// File: Makefile
# Verilator simulation of the AXI4 read burst unwrapper

TOP := tb_burst_unwrap
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f compile.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q -F "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
